/* common/dvi_pkg.sv */
// Shared raster constants, TMDS control tokens, record types and helpers for the DVI transmitter

package dvi_pkg;

	// ------------------------------------------------
	// Channel and word widths
	// ------------------------------------------------
	localparam int k_bits_in      = 8;
	localparam int k_encoded_bits = 10;
	localparam int k_num_channels = 3;

	// ------------------------------------------------
	// Test raster, pixels per line and lines per frame
	// ------------------------------------------------
	localparam int k_h_active = 16;
	localparam int k_h_front  = 2;
	localparam int k_h_sync   = 4;
	localparam int k_h_back   = 6;
	localparam int k_h_total  = k_h_active + k_h_front + k_h_sync + k_h_back;

	localparam int k_v_active = 6;
	localparam int k_v_front  = 1;
	localparam int k_v_sync   = 2;
	localparam int k_v_back   = 2;
	localparam int k_v_total  = k_v_active + k_v_front + k_v_sync + k_v_back;

	// Counter widths sized for the longest phase and the whole frame
	localparam int k_h_cnt_bits = $clog2(k_h_total);
	localparam int k_v_cnt_bits = $clog2(k_v_total);

	// Control tokens sent in blanking, indexed by {C1, C0}
	localparam logic [k_encoded_bits-1:0] k_ctl_tkn0 = 10'b1101010100;
	localparam logic [k_encoded_bits-1:0] k_ctl_tkn1 = 10'b0010101011;
	localparam logic [k_encoded_bits-1:0] k_ctl_tkn2 = 10'b0101010100;
	localparam logic [k_encoded_bits-1:0] k_ctl_tkn3 = 10'b1010101011;

	// ------------------------------------------------
	// Record types
	// ------------------------------------------------
	typedef struct packed {
		logic [k_bits_in-1:0] red;
		logic [k_bits_in-1:0] green;
		logic [k_bits_in-1:0] blue;
	} rgb_t;

	// Everything one encoder needs for one pixel clock
	typedef struct packed {
		logic [k_bits_in-1:0] data;
		logic                 c0;
		logic                 c1;
		logic                 de;
	} tmds_chan_t;

	typedef logic [k_encoded_bits-1:0] tmds_word_t;

	// Parallel link toward the external serializer
	typedef struct packed {
		tmds_word_t ch0;
		tmds_word_t ch1;
		tmds_word_t ch2;
		logic       hsync;
		logic       vsync;
		logic       de;
	} tmds_link_t;

	typedef enum logic [1:0] {
		h_active,
		h_front,
		h_sync,
		h_back
	} h_phase_t;

	// Number of set bits in one data byte
	function automatic logic [3:0] ones_count(input logic [k_bits_in-1:0] value);
		logic [3:0] total;
		total = '0;
		for (int i = 0; i < k_bits_in; i++) begin
			total = total + 4'(value[i]);
		end
		return total;
	endfunction

endpackage

/* hw/video_timing.sv */
// Raster timing generator that requests pixels and builds the three TMDS channel records

`timescale 1ns/1ps

module video_timing import dvi_pkg::*; (
	input  logic                               rst,
	input  logic                               PixelClk,
	input  rgb_t                               pixel,
	output logic                               pixel_req,
	output tmds_chan_t [k_num_channels-1:0]    chan
);

	// ------------------------------------------------
	// Raster state
	// ------------------------------------------------
	h_phase_t                h_phase;
	logic [k_h_cnt_bits-1:0] h_cnt;
	logic [k_v_cnt_bits-1:0] v_cnt;
	logic                    h_end;
	logic                    v_end;
	logic                    v_active;
	logic                    hsync;
	logic                    vsync;

	// The pixel counter restarts in every phase, so the end depends on the phase length
	always_comb begin
		case (h_phase)
			h_active: h_end = (h_cnt == k_h_cnt_bits'(k_h_active - 1));
			h_front:  h_end = (h_cnt == k_h_cnt_bits'(k_h_front - 1));
			h_sync:   h_end = (h_cnt == k_h_cnt_bits'(k_h_sync - 1));
			default:  h_end = (h_cnt == k_h_cnt_bits'(k_h_back - 1));
		endcase
	end

	// Last pixel of the last line closes the frame
	assign v_end = (v_cnt == k_v_cnt_bits'(k_v_total - 1));

	// Vertical decode straight from the line counter
	assign v_active = (v_cnt < k_v_cnt_bits'(k_v_active));
	assign vsync = (v_cnt >= k_v_cnt_bits'(k_v_active + k_v_front)) &&
		(v_cnt < k_v_cnt_bits'(k_v_active + k_v_front + k_v_sync));

	assign hsync = (h_phase == h_sync);

	// One request per active pixel, never in a blanking line
	assign pixel_req = (h_phase == h_active) && v_active;

	// ------------------------------------------------
	// Horizontal FSM and line counter
	// ------------------------------------------------
	always_ff @(posedge PixelClk) begin
		if (rst) begin
			// Park on the last back porch pixel of the frame
			// so the first edge after reset lands on pixel 0 of line 0
			h_phase <= h_back;
			h_cnt <= k_h_cnt_bits'(k_h_back - 1);
			v_cnt <= k_v_cnt_bits'(k_v_total - 1);
		end else begin
			if (h_end) begin
				h_cnt <= '0;
				case (h_phase)
					h_active: h_phase <= h_front;
					h_front:  h_phase <= h_sync;
					h_sync:   h_phase <= h_back;
					default:  h_phase <= h_active;
				endcase
				// A line ends with its back porch
				if (h_phase == h_back) begin
					if (v_end) begin
						v_cnt <= '0;
					end else begin
						v_cnt <= v_cnt + 1'b1;
					end
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// ------------------------------------------------
	// Channel records
	// ------------------------------------------------
	// Blue rides with the sync bits on channel 0 as DVI requires
	// Green and red channels always send zero control bits
	always_ff @(posedge PixelClk) begin
		if (rst) begin
			chan <= '0;
		end else begin
			chan[0].data <= pixel_req ? pixel.blue : '0;
			chan[0].c0 <= hsync;
			chan[0].c1 <= vsync;
			chan[0].de <= pixel_req;

			chan[1].data <= pixel_req ? pixel.green : '0;
			chan[1].c0 <= 1'b0;
			chan[1].c1 <= 1'b0;
			chan[1].de <= pixel_req;

			chan[2].data <= pixel_req ? pixel.red : '0;
			chan[2].c0 <= 1'b0;
			chan[2].c1 <= 1'b0;
			chan[2].de <= pixel_req;
		end
	end

endmodule

/* tmds_encoder/tmds_encoder.sv */
// One TMDS channel encoder, turning a channel record into a 10-bit word three cycles later

`timescale 1ns/1ps

module tmds_encoder import dvi_pkg::*; (
	input  logic       rst,
	input  logic       PixelClk,
	input  tmds_chan_t chan,
	output tmds_word_t word
);

	// Stage 1 state
	tmds_chan_t        chan_1;
	logic [3:0]        n1d_1;
	logic              use_xnor_1;
	logic [8:0]        q_m_1;

	// Stage 2 state
	logic [8:0]        q_m_2;
	logic [3:0]        n1q_m_2;
	logic [1:0]        ctl_2;
	logic              de_2;

	// Balance decision
	logic signed [4:0] n1_s;
	logic signed [4:0] n0_s;
	logic              balanced_2;
	logic              invert_2;
	tmds_word_t        token_2;
	tmds_word_t        word_nxt;
	logic signed [4:0] disp_nxt;

	// Running disparity after the word now on the output, ones minus zeros
	logic signed [4:0] disp;

	// ------------------------------------------------
	// Stage 1, transition minimising
	// ------------------------------------------------
	always_ff @(posedge PixelClk) begin
		if (rst) begin
			chan_1.de <= 1'b0;
		end else begin
			chan_1.de <= chan.de;
		end
		chan_1.data <= chan.data;
		chan_1.c0 <= chan.c0;
		chan_1.c1 <= chan.c1;
		n1d_1 <= ones_count(chan.data);
	end

	// XNOR is used for bytes heavy in ones, and on a tie when bit 0 is clear
	assign use_xnor_1 = (n1d_1 > 4'd4) || ((n1d_1 == 4'd4) && !chan_1.data[0]);

	always_comb begin
		q_m_1[0] = chan_1.data[0];
		for (int i = 1; i < k_bits_in; i++) begin
			if (use_xnor_1) begin
				q_m_1[i] = ~(q_m_1[i-1] ^ chan_1.data[i]);
			end else begin
				q_m_1[i] = q_m_1[i-1] ^ chan_1.data[i];
			end
		end
		// Bit 8 tells the receiver which chain was applied
		q_m_1[8] = ~use_xnor_1;
	end

	// ------------------------------------------------
	// Stage 2, DC balancing
	// ------------------------------------------------
	always_ff @(posedge PixelClk) begin
		if (rst) begin
			de_2 <= 1'b0;
		end else begin
			de_2 <= chan_1.de;
		end
		q_m_2 <= q_m_1;
		n1q_m_2 <= ones_count(q_m_1[7:0]);
		ctl_2 <= {chan_1.c1, chan_1.c0};
	end

	// Ones and zeros of the eight data bits as signed counts
	assign n1_s = signed'({1'b0, n1q_m_2});
	assign n0_s = 5'sd8 - n1_s;

	// No history to correct, or a word that is neutral on its own
	assign balanced_2 = (disp == 5'sd0) || (n1q_m_2 == 4'd4);

	// Inverting pulls the disparity back toward zero
	assign invert_2 = ((disp > 5'sd0) && (n1q_m_2 > 4'd4)) ||
		((disp < 5'sd0) && (n1q_m_2 < 4'd4));

	always_comb begin
		case (ctl_2)
			2'b00:   token_2 = k_ctl_tkn0;
			2'b01:   token_2 = k_ctl_tkn1;
			2'b10:   token_2 = k_ctl_tkn2;
			default: token_2 = k_ctl_tkn3;
		endcase
	end

	always_comb begin
		if (!de_2) begin
			// Blanking sends a token and restarts the balance
			word_nxt = token_2;
			disp_nxt = 5'sd0;
		end else if (balanced_2) begin
			// Bit 9 is the complement of bit 8 here, data inverted for the XNOR chain
			if (q_m_2[8]) begin
				word_nxt = {1'b0, 1'b1, q_m_2[7:0]};
				disp_nxt = disp + n1_s - n0_s;
			end else begin
				word_nxt = {1'b1, 1'b0, ~q_m_2[7:0]};
				disp_nxt = disp + n0_s - n1_s;
			end
		end else if (invert_2) begin
			word_nxt = {1'b1, q_m_2[8], ~q_m_2[7:0]};
			disp_nxt = disp + (q_m_2[8] ? 5'sd2 : 5'sd0) + n0_s - n1_s;
		end else begin
			word_nxt = {1'b0, q_m_2[8], q_m_2[7:0]};
			disp_nxt = disp - (q_m_2[8] ? 5'sd0 : 5'sd2) + n1_s - n0_s;
		end
	end

	// ------------------------------------------------
	// Stage 3, output word and disparity
	// ------------------------------------------------
	always_ff @(posedge PixelClk) begin
		if (rst) begin
			word <= '0;
			disp <= 5'sd0;
		end else begin
			word <= word_nxt;
			disp <= disp_nxt;
		end
	end

endmodule

/* hw/dvi_tx_top.sv */
// DVI transmitter front end, raster timing plus three TMDS encoders feeding a parallel link

`timescale 1ns/1ps

module dvi_tx_top import dvi_pkg::*; (
	input  logic       rst,
	input  logic       PixelClk,
	input  rgb_t       pixel,
	output logic       pixel_req,
	output tmds_link_t link
);

	tmds_chan_t [k_num_channels-1:0] chan;
	tmds_word_t [k_num_channels-1:0] words;

	// Sync state delayed to line up with the encoder pipeline
	logic [2:0]                      hs_dly;
	logic [2:0]                      vs_dly;
	logic [2:0]                      de_dly;

	video_timing i_timing (
		.rst       (rst),
		.PixelClk  (PixelClk),
		.pixel     (pixel),
		.pixel_req (pixel_req),
		.chan      (chan)
	);

	// ------------------------------------------------
	// One encoder per colour channel
	// ------------------------------------------------
	for (genvar g = 0; g < k_num_channels; g++) begin : g_enc
		tmds_encoder i_enc (
			.rst      (rst),
			.PixelClk (PixelClk),
			.chan     (chan[g]),
			.word     (words[g])
		);
	end

	// Channel 0 carries hsync and vsync, so its record is the source
	// Three stages match the three register stages of each encoder
	always_ff @(posedge PixelClk) begin
		if (rst) begin
			hs_dly <= '0;
			vs_dly <= '0;
			de_dly <= '0;
		end else begin
			hs_dly <= {hs_dly[1:0], chan[0].c0};
			vs_dly <= {vs_dly[1:0], chan[0].c1};
			de_dly <= {de_dly[1:0], chan[0].de};
		end
	end

	// Output struct toward the serializer
	assign link.ch0 = words[0];
	assign link.ch1 = words[1];
	assign link.ch2 = words[2];
	assign link.hsync = hs_dly[2];
	assign link.vsync = vs_dly[2];
	assign link.de = de_dly[2];

endmodule

/* bench/dvi_tx_asserts.sv */
// Concurrent checks bound into each TMDS encoder and into the raster generator

`timescale 1ns/1ps

module dvi_tx_asserts import dvi_pkg::*; (
	input logic              PixelClk,
	input logic              rst,
	input logic signed [4:0] disp,
	input logic              de_2,
	input tmds_word_t        word,
	input logic              pixel_req,
	input logic              hsync
);

	// A balanced stream never drifts more than one byte of ones or zeros
	disp_range: assert property (@(posedge PixelClk) disable iff (rst)
		(disp >= -5'sd8) && (disp <= 5'sd8))
		else $error("Running disparity %0d outside -8 to 8", disp);

	// A word built from a blanking record is a control token
	// The word written by the last reset edge is zero and is no token
	blank_token: assert property (@(posedge PixelClk) disable iff (rst)
		(!$past(rst) && !$past(de_2)) |-> ((word == k_ctl_tkn0) || (word == k_ctl_tkn1) ||
		(word == k_ctl_tkn2) || (word == k_ctl_tkn3)))
		else $error("Blanking word %h is not a control token", word);

	// The back porch keeps every line's first request away from its hsync
	req_after_porch: assert property (@(posedge PixelClk) disable iff (rst)
		$rose(pixel_req) |-> !$past(hsync))
		else $error("Pixel request raised straight out of hsync");

endmodule

// --------------------------------------------------
// The encoders have no raster signals so those inputs are tied off
bind tmds_encoder dvi_tx_asserts i_asserts (
	.PixelClk  (PixelClk),
	.rst       (rst),
	.disp      (disp),
	.de_2      (de_2),
	.word      (word),
	.pixel_req (1'b0),
	.hsync     (1'b0)
);

// The raster generator ties the encoder inputs to a quiet active state
bind video_timing dvi_tx_asserts i_asserts (
	.PixelClk  (PixelClk),
	.rst       (rst),
	.disp      (5'sd0),
	.de_2      (1'b1),
	.word      (10'd0),
	.pixel_req (pixel_req),
	.hsync     (hsync)
);

/* bench/dvi_tx_tb.sv */
// Self-checking testbench that drives random pixels into the DVI transmitter and checks the link

`timescale 1ns/1ps

module dvi_tx_tb import dvi_pkg::*; ();

	logic       PixelClk;
	logic       rst;
	rgb_t       pixel;
	logic       pixel_req;
	tmds_link_t link;

	// Pixels taken by the DUT and not yet seen on the link
	rgb_t       pix_q[$];
	int         disp_m[k_num_channels];
	int         chk_cnt[5];
	int         err_cnt[5];
	string      test_name[5];
	int         phase;
	int         settle;
	bit         timed_out;

	// Raster bookkeeping built from the delayed sync outputs
	logic       hs_prev;
	logic       vs_prev;
	int         line_de;
	int         hs_len;
	int         lines;
	int         act_lines;
	int         vs_lines;
	int         frames;
	bit         frame_open;

	dvi_tx_top i_dut (
		.rst       (rst),
		.PixelClk  (PixelClk),
		.pixel     (pixel),
		.pixel_req (pixel_req),
		.link      (link)
	);

	always #50 PixelClk = ~PixelClk;

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	// DVI 1.0 encoding written out from the standard with one disparity per channel
	function automatic tmds_word_t encode_model(input logic [7:0] d, input int ch);
		logic [8:0] qm;
		logic       xnor_sel;
		int         n1;
		int         n0;
		tmds_word_t w;
		xnor_sel = (ones_count(d) > 4'd4) ||
			((ones_count(d) == 4'd4) && (d[0] == 1'b0));
		qm[0] = d[0];
		for (int i = 1; i < 8; i++) begin
			qm[i] = xnor_sel ? (qm[i-1] ~^ d[i]) : (qm[i-1] ^ d[i]);
		end
		qm[8] = !xnor_sel;
		n1 = int'(ones_count(qm[7:0]));
		n0 = 8 - n1;
		if ((disp_m[ch] == 0) || (n1 == n0)) begin
			w = {~qm[8], qm[8], (qm[8] ? qm[7:0] : ~qm[7:0])};
			disp_m[ch] += qm[8] ? (n1 - n0) : (n0 - n1);
		end else if (((disp_m[ch] > 0) && (n1 > n0)) ||
				((disp_m[ch] < 0) && (n0 > n1))) begin
			w = {1'b1, qm[8], ~qm[7:0]};
			disp_m[ch] += 2 * int'(qm[8]) + n0 - n1;
		end else begin
			w = {1'b0, qm[8], qm[7:0]};
			disp_m[ch] += n1 - n0 - 2 * int'(!qm[8]);
		end
		return w;
	endfunction

	// Receiver side decode that needs no disparity history
	function automatic logic [7:0] decode_word(input tmds_word_t w);
		logic [7:0] q;
		logic [7:0] d;
		q = w[9] ? ~w[7:0] : w[7:0];
		d[0] = q[0];
		for (int i = 1; i < 8; i++) begin
			d[i] = w[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
		end
		return d;
	endfunction

	function automatic tmds_word_t token_for(input logic c1, input logic c0);
		tmds_word_t t;
		case ({c1, c0})
			2'b00:   t = k_ctl_tkn0;
			2'b01:   t = k_ctl_tkn1;
			2'b10:   t = k_ctl_tkn2;
			default: t = k_ctl_tkn3;
		endcase
		return t;
	endfunction

	// After the mid-frame reset every check is booked under the reset test
	function automatic int test_for(input int base);
		return (phase == 0) ? base : 4;
	endfunction

	task automatic note_mismatch(input int t, input string what, input logic [31:0] expv,
			input logic [31:0] actv);
		err_cnt[t]++;
		$display("FAIL %s %s expected %0h actual %0h", test_name[t], what, expv, actv);
	endtask

	task automatic report_problem(input int t, input string msg);
		err_cnt[t]++;
		$display("Error in %s, %s", test_name[t], msg);
	endtask

	// --------------------------------------------------
	// Link checks called once per settled cycle
	// --------------------------------------------------
	task automatic check_link();
		rgb_t       p;
		logic [7:0] byte_v[k_num_channels];
		tmds_word_t word_v[k_num_channels];
		tmds_word_t exp_w;
		int         tr;
		word_v[0] = link.ch0;
		word_v[1] = link.ch1;
		word_v[2] = link.ch2;
		tr = test_for(3);
		if (link.de && (pix_q.size() == 0)) begin
			report_problem(test_for(0), "link.de high with no pixel queued");
		end else if (link.de) begin
			p = pix_q.pop_front();
			// Blue on channel 0, green on 1, red on 2
			byte_v[0] = p.blue;
			byte_v[1] = p.green;
			byte_v[2] = p.red;
			for (int ch = 0; ch < k_num_channels; ch++) begin
				exp_w = encode_model(byte_v[ch], ch);
				chk_cnt[test_for(0)]++;
				if (word_v[ch] !== exp_w) begin
					note_mismatch(test_for(0), $sformatf("ch%0d word", ch), 32'(exp_w),
						32'(word_v[ch]));
				end
				chk_cnt[test_for(2)]++;
				if (decode_word(word_v[ch]) !== byte_v[ch]) begin
					note_mismatch(test_for(2), $sformatf("ch%0d byte", ch), 32'(byte_v[ch]),
						32'(decode_word(word_v[ch])));
				end
			end
		end else begin
			// A blanking word clears the balance on every channel
			for (int ch = 0; ch < k_num_channels; ch++) begin
				disp_m[ch] = 0;
			end
			exp_w = token_for(link.vsync, link.hsync);
			chk_cnt[test_for(1)]++;
			if (link.ch0 !== exp_w) begin
				note_mismatch(test_for(1), "ch0 token", 32'(exp_w), 32'(link.ch0));
			end
			chk_cnt[test_for(1)]++;
			if ((link.ch1 !== k_ctl_tkn0) || (link.ch2 !== k_ctl_tkn0)) begin
				note_mismatch(test_for(1), "ch1/ch2 token", 32'(k_ctl_tkn0),
					32'({link.ch1, link.ch2}));
			end
		end

		if (link.de) line_de++;
		if (link.hsync) hs_len++;
		// The falling edge of hsync closes one line
		if (hs_prev && !link.hsync) begin
			chk_cnt[tr]++;
			if (hs_len != k_h_sync) note_mismatch(tr, "hsync length", k_h_sync, hs_len);
			if (line_de != 0) begin
				chk_cnt[tr]++;
				if (line_de != k_h_active) begin
					note_mismatch(tr, "de per line", k_h_active, line_de);
				end
				act_lines++;
			end
			if (link.vsync) vs_lines++;
			lines++;
			hs_len = 0;
			line_de = 0;
		end
		// Rising vsync is the frame boundary
		if (link.vsync && !vs_prev) begin
			chk_cnt[tr]++;
			if (frame_open) begin
				if (lines != k_v_total) begin
					note_mismatch(tr, "lines per frame", k_v_total, lines);
				end
				if (act_lines != k_v_active) begin
					note_mismatch(tr, "active lines", k_v_active, act_lines);
				end
				if (vs_lines != k_v_sync) begin
					note_mismatch(tr, "vsync lines", k_v_sync, vs_lines);
				end
				frames++;
			end else begin
				// Lines 0 to 6 come before the first vsync when the raster starts at line 0
				if (lines != k_v_active + k_v_front) begin
					note_mismatch(tr, "lines before first vsync", k_v_active + k_v_front,
						lines);
				end
				if (act_lines != k_v_active) begin
					note_mismatch(tr, "active lines before first vsync", k_v_active,
						act_lines);
				end
			end
			frame_open = 1'b1;
			lines = 0;
			act_lines = 0;
			vs_lines = 0;
		end
		hs_prev = link.hsync;
		vs_prev = link.vsync;
	endtask

	// Outputs are sampled on the falling edge halfway between driving edges
	always @(negedge PixelClk) begin
		if (rst) begin
			pix_q.delete();
			settle = 0;
			for (int ch = 0; ch < k_num_channels; ch++) begin
				disp_m[ch] = 0;
			end
			hs_prev = 1'b0;
			vs_prev = 1'b0;
			line_de = 0;
			hs_len = 0;
			lines = 0;
			act_lines = 0;
			vs_lines = 0;
			frame_open = 1'b0;
		end else begin
			if (pixel_req) pix_q.push_back(pixel);
			// The first words after reset leave unreset pipeline stages
			if (settle < 4) begin
				settle++;
			end else begin
				check_link();
			end
		end
	end

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	task automatic next_cycle();
		@(posedge PixelClk);
		pixel <= 24'($urandom);
	endtask

	task automatic wait_frames(input int target);
		int cycles;
		cycles = 0;
		while ((frames < target) && (cycles < 4 * k_h_total * k_v_total)) begin
			next_cycle();
			cycles++;
		end
		if (frames < target) begin
			timed_out = 1'b1;
			$display("Timeout while waiting for frame %0d, only %0d complete", target, frames);
		end
	endtask

	task automatic print_test(input int t);
		if (chk_cnt[t] == 0) report_problem(t, "no checks ran");
		$display("Test %s finished, %0d checks, %0d errors", test_name[t], chk_cnt[t],
			err_cnt[t]);
	endtask

	initial begin
		int unsigned seed_ret;
		int          delay;
		int          total_chk;
		int          total_err;
		test_name = '{"active_words", "blanking_tokens", "decode_round_trip", "raster",
			"mid_frame_reset"};
		PixelClk = 1'b0;
		rst = 1'b1;
		pixel = '0;
		phase = 0;
		frames = 0;
		timed_out = 1'b0;
		seed_ret = $urandom(32'h3ac2_3f22);

		repeat (4) next_cycle();
		rst <= 1'b0;
		wait_frames(2);
		for (int t = 0; t < 4; t++) begin
			print_test(t);
		end

		// Second reset somewhere inside a frame
		phase = 1;
		delay = 40 + int'($urandom % 150);
		repeat (delay) next_cycle();
		rst <= 1'b1;
		for (int k = 0; k < 4; k++) begin
			next_cycle();
			if (k == 3) rst <= 1'b0;
			@(negedge PixelClk);
			chk_cnt[4]++;
			if (pixel_req !== 1'b0) report_problem(4, "pixel_req high during reset");
		end
		if (!timed_out) wait_frames(frames + 1);
		print_test(4);

		total_chk = 0;
		total_err = 0;
		for (int t = 0; t < 5; t++) begin
			total_chk += chk_cnt[t];
			total_err += err_cnt[t];
		end
		$display("Totals %0d checks, %0d errors, timeout %0d", total_chk, total_err, timed_out);
		if ((total_err == 0) && !timed_out) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
common/dvi_pkg.sv
hw/video_timing.sv
tmds_encoder/tmds_encoder.sv
hw/dvi_tx_top.sv
bench/dvi_tx_asserts.sv
bench/dvi_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run the testbench and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dvi_tx_tb -f filelist.f \
	-o dvi_tx_sim \
	&& ./obj_dir/dvi_tx_sim > sim.log 2>&1 \
	|| echo "Build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -sqx "Regression passed" sim.log && echo "Simulation result: pass" && exit 0 \
	|| echo "Simulation result: fail" && exit 1
